// File: src/pkt_pkg.sv
package pkt_pkg;

    // ~~~~~~~~~~~~~~~~~~~~
    // basic scalar types.
    // ~~~~~~~~~~~~~~~~~~~~
    typedef logic [15:0] hw_t;       // one packet halfword.
    typedef logic [3:0]  port_id_t;  // destination port, header bits 3..0.
    typedef logic [8:0]  pkt_len_t;  // length in halfwords, header included.

    // one input cycle from a source port.
    typedef struct packed {
        logic sop;   // first halfword of a packet.
        logic eop;   // last halfword of a packet.
        logic vld;   // data is valid this cycle.
        hw_t  data;
    } in_beat_t;

    // one frontend output cycle toward the merger.
    typedef struct packed {
        logic vld;
        hw_t  data;
        logic eop;   // marks the last halfword of the packet.
    } xfer_beat_t;

    // match request, raised once the header is captured.
    typedef struct packed {
        logic     enable;
        port_id_t dest;
        pkt_len_t length;
    } match_req_t;

    // merged output cycle, tagged with source and destination.
    typedef struct packed {
        logic     vld;
        hw_t      data;
        logic     eop;
        logic     src;   // frontend the beat came from.
        port_id_t dest;
    } out_beat_t;

    // ~~~~~~~~~~~~~~~~~~~~
    // controller states.
    // ~~~~~~~~~~~~~~~~~~~~
    typedef enum logic {arb_idle, arb_busy} arb_state_e;
    typedef enum logic {merge_idle, merge_stream} merge_state_e;

endpackage

// File: src/port_wr_frontend.sv
`timescale 1ns/10ps

module port_wr_frontend #(
    parameter int buf_aw = 6   // buffer address width.
) (
    input  logic                clk,
    input  logic                rst_n,
    input  pkt_pkg::in_beat_t   in_beat,
    output logic                pause,
    output pkt_pkg::match_req_t req,
    input  logic                grant,
    output pkt_pkg::xfer_beat_t xfer
);
    import pkt_pkg::*;

    localparam int depth = 1 << buf_aw;
    // pause once two or fewer free slots remain.
    localparam logic [buf_aw-1:0] full_mark = buf_aw'(depth - 3);

    typedef enum logic [1:0] {wr_idle, wr_armed, wr_writing, wr_done} wr_state_e;
    typedef enum logic [1:0] {xf_idle, xf_send, xf_stall} xf_state_e;

    wr_state_e wr_state;
    xf_state_e xf_state;

    hw_t               buffer [depth];  // circular halfword buffer.
    logic [buf_aw-1:0] wr_ptr;
    logic [buf_aw-1:0] xfer_ptr;
    logic [buf_aw-1:0] wr_ptr_nxt;
    logic [buf_aw-1:0] xfer_ptr_nxt;
    logic [buf_aw-1:0] used_nxt;        // fill level after this cycle.

    pkt_len_t wr_cnt;      // halfwords written of the current packet.
    pkt_len_t hdr_len;
    port_id_t hdr_dest;
    logic     req_enable;
    logic     grant_pend;  // grant seen while a packet still drains.
    pkt_len_t grant_len;
    pkt_len_t xfer_rem;    // halfwords left to send.

    logic hdr_wr;
    logic body_wr;
    logic wr_en;
    logic last_wr;
    logic start;
    logic rd_en;
    logic xfer_vld;
    logic xfer_eop;
    hw_t  xfer_data;

    // ~~~~~~~~~~~~~~~~~~~~
    // write side.
    // ~~~~~~~~~~~~~~~~~~~~
    // header comes with sop, or on the first vld after a bare sop.
    assign hdr_wr  = in_beat.vld && (wr_state == wr_armed ||
                     (in_beat.sop && (wr_state == wr_idle || wr_state == wr_done)));
    assign body_wr = in_beat.vld && wr_state == wr_writing;
    assign wr_en   = hdr_wr || body_wr;
    assign last_wr = body_wr && (in_beat.eop || wr_cnt == hdr_len - pkt_len_t'(1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_state <= wr_idle;
        end else begin
            case (wr_state)
                wr_idle, wr_done: begin  // done also takes a back-to-back sop.
                    if (hdr_wr) begin
                        wr_state <= wr_writing;
                    end else if (in_beat.sop) begin
                        wr_state <= wr_armed;
                    end else begin
                        wr_state <= wr_idle;
                    end
                end
                wr_armed: if (hdr_wr) wr_state <= wr_writing;
                wr_writing: if (last_wr) wr_state <= wr_done;  // length reached.
                default: wr_state <= wr_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) buffer[wr_ptr] <= in_beat.data;
        if (hdr_wr) begin
            hdr_dest <= in_beat.data[3:0];
            hdr_len  <= in_beat.data[15:7];
        end
        if (grant) grant_len <= hdr_len;  // kept for a deferred start.
    end

    assign wr_ptr_nxt   = wr_ptr + buf_aw'(wr_en);
    assign xfer_ptr_nxt = xfer_ptr + buf_aw'(rd_en);
    assign used_nxt     = wr_ptr_nxt - xfer_ptr_nxt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            xfer_ptr <= '0;
            wr_cnt   <= '0;
        end else begin
            wr_ptr   <= wr_ptr_nxt;
            xfer_ptr <= xfer_ptr_nxt;
            if (hdr_wr) begin
                wr_cnt <= pkt_len_t'(1);
            end else if (body_wr) begin
                wr_cnt <= wr_cnt + pkt_len_t'(1);
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // match request.
    // ~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_enable <= 1'b0;
            grant_pend <= 1'b0;
        end else begin
            if (hdr_wr) begin
                req_enable <= 1'b1;  // one cycle after the header write.
            end else if (grant) begin
                req_enable <= 1'b0;
            end
            if (start) begin
                grant_pend <= 1'b0;
            end else if (grant) begin
                grant_pend <= 1'b1;
            end
        end
    end

    assign req = '{enable: req_enable, dest: hdr_dest, length: hdr_len};

    // ~~~~~~~~~~~~~~~~~~~~
    // transfer side.
    // ~~~~~~~~~~~~~~~~~~~~
    assign start = xf_state == xf_idle && (grant || grant_pend);
    assign rd_en = xf_state == xf_send;  // send always has data buffered.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            xf_state <= xf_idle;
            xfer_rem <= '0;
        end else begin
            case (xf_state)
                xf_idle: if (start) begin
                    xf_state <= xf_send;
                    xfer_rem <= grant ? hdr_len : grant_len;
                end
                xf_send: begin
                    xfer_rem <= xfer_rem - pkt_len_t'(1);
                    if (xfer_rem == pkt_len_t'(1)) begin
                        xf_state <= xf_idle;               // last halfword read.
                    end else if (xfer_ptr_nxt == wr_ptr && !wr_en) begin
                        xf_state <= xf_stall;              // caught up with writer.
                    end
                end
                xf_stall: if (xfer_ptr != wr_ptr) xf_state <= xf_send;
                default: xf_state <= xf_idle;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            xfer_vld <= 1'b0;
            xfer_eop <= 1'b0;
            pause    <= 1'b0;
        end else begin
            xfer_vld <= rd_en;
            xfer_eop <= rd_en && xfer_rem == pkt_len_t'(1);
            // near full, or an unmatched request with no packet in flight.
            pause <= (used_nxt >= full_mark) ||
                     (req_enable && (wr_state != wr_writing || last_wr));
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) xfer_data <= buffer[xfer_ptr];
    end

    assign xfer = '{vld: xfer_vld, data: xfer_data, eop: xfer_eop};

endmodule

// File: src/match_arbiter.sv
`timescale 1ns/10ps

module match_arbiter (
    input  logic                clk,
    input  logic                rst_n,
    input  pkt_pkg::match_req_t req0,
    input  logic                pkt_done,
    input  pkt_pkg::match_req_t req1,
    output logic                grant0,
    output logic                grant1,
    output logic                sel
);
    import pkt_pkg::*;

    arb_state_e state;
    logic       last_served;  // port granted most recently.
    logic       any_req;
    logic       pick;         // port to grant this cycle.

    // only enable decides for now.
    // dest and length stay on the bus for a later SRAM preference check.
    assign any_req = req0.enable || req1.enable;

    // ~~~~~~~~~~~~~~~~~~~~
    // round robin pick.
    // ~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        if (req0.enable && req1.enable) begin
            pick = ~last_served;  // both wait, serve the other one.
        end else begin
            pick = req1.enable;   // single requester wins.
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // grant FSM.
    // ~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= arb_idle;
            grant0      <= 1'b0;
            grant1      <= 1'b0;
            last_served <= 1'b0;
        end else begin
            grant0 <= 1'b0;  // grants are single-cycle pulses.
            grant1 <= 1'b0;
            case (state)
                arb_idle: begin
                    if (any_req) begin
                        grant0      <= ~pick;
                        grant1      <= pick;
                        last_served <= pick;
                        state       <= arb_busy;
                    end
                end
                arb_busy: begin
                    // one packet in flight until the merger sees its eop.
                    if (pkt_done) state <= arb_idle;
                end
                default: state <= arb_idle;
            endcase
        end
    end

    // the last-served port also steers the merger.
    // it only changes on a grant, so it holds through the packet.
    assign sel = last_served;

endmodule

// File: src/stream_merger.sv
`timescale 1ns/10ps

module stream_merger (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                sel,
    input  pkt_pkg::port_id_t   dest0,
    input  pkt_pkg::port_id_t   dest1,
    input  pkt_pkg::xfer_beat_t xfer0,
    input  pkt_pkg::xfer_beat_t xfer1,
    output pkt_pkg::out_beat_t  out,
    output logic                pkt_done,
    output logic [15:0]         pkt_count
);
    import pkt_pkg::*;

    merge_state_e state;

    xfer_beat_t beat;       // stream of the selected frontend.
    port_id_t   cur_dest;   // dest offered by the selected frontend.
    port_id_t   dest_q;     // dest held for the rest of the packet.
    logic       last_beat;

    logic     out_vld;
    logic     out_eop;
    hw_t      out_data;
    logic     out_src;
    port_id_t out_dest;

    // ~~~~~~~~~~~~~~~~~~~~
    // source select.
    // ~~~~~~~~~~~~~~~~~~~~
    assign beat      = sel ? xfer1 : xfer0;
    assign cur_dest  = sel ? dest1 : dest0;
    assign last_beat = beat.vld && beat.eop;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= merge_idle;
            out_vld   <= 1'b0;
            out_eop   <= 1'b0;
            pkt_count <= '0;
        end else begin
            out_vld <= beat.vld;   // one cycle behind the xfer beat.
            out_eop <= last_beat;
            if (last_beat) pkt_count <= pkt_count + 16'd1;
            case (state)
                merge_idle: begin
                    // a one-beat packet never leaves idle.
                    if (beat.vld && !beat.eop) state <= merge_stream;
                end
                merge_stream: if (last_beat) state <= merge_idle;
                default: state <= merge_idle;
            endcase
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // payload and tags.
    // ~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (beat.vld) begin
            out_data <= beat.data;
            out_src  <= sel;
            // first beat takes the live dest, later beats the latched one.
            out_dest <= (state == merge_idle) ? cur_dest : dest_q;
        end
        if (state == merge_idle && beat.vld) begin
            dest_q <= cur_dest;  // frontend header may change after this.
        end
    end

    assign out = '{
        vld:  out_vld,
        data: out_data,
        eop:  out_eop,
        src:  out_src,
        dest: out_dest
    };

    // done coincides with the eop output cycle.
    assign pkt_done = out_eop;

endmodule

// File: src/switch_ingress.sv
`timescale 1ns/10ps

module switch_ingress #(
    parameter int buf_aw = 6   // frontend buffer address width.
) (
    input  logic               clk,
    input  logic               rst_n,
    input  pkt_pkg::in_beat_t  in0,
    input  pkt_pkg::in_beat_t  in1,
    output logic               pause0,
    output logic               pause1,
    output pkt_pkg::out_beat_t out,
    output logic [15:0]        pkt_count
);
    import pkt_pkg::*;

    match_req_t req0;
    match_req_t req1;
    xfer_beat_t xfer0;
    xfer_beat_t xfer1;
    logic       grant0;
    logic       grant1;
    logic       sel;       // port currently streaming.
    logic       pkt_done;  // frees the arbiter.

    // ~~~~~~~~~~~~~~~~~~~~
    // input frontends.
    // ~~~~~~~~~~~~~~~~~~~~
    port_wr_frontend #(.buf_aw(buf_aw)) fe0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .in_beat (in0),
        .pause   (pause0),
        .req     (req0),
        .grant   (grant0),
        .xfer    (xfer0)
    );

    port_wr_frontend #(.buf_aw(buf_aw)) fe1 (
        .clk     (clk),
        .rst_n   (rst_n),
        .in_beat (in1),
        .pause   (pause1),
        .req     (req1),
        .grant   (grant1),
        .xfer    (xfer1)
    );

    // ~~~~~~~~~~~~~~~~~~~~
    // match and merge.
    // ~~~~~~~~~~~~~~~~~~~~
    match_arbiter arb0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .req0     (req0),
        .pkt_done (pkt_done),
        .req1     (req1),
        .grant0   (grant0),
        .grant1   (grant1),
        .sel      (sel)
    );

    stream_merger mrg0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .sel       (sel),
        .dest0     (req0.dest),  // header dest, stable until the first beat.
        .dest1     (req1.dest),
        .xfer0     (xfer0),
        .xfer1     (xfer1),
        .out       (out),
        .pkt_done  (pkt_done),
        .pkt_count (pkt_count)
    );

endmodule

// File: bench/ingress_checker.sv
`timescale 1ns/10ps

module ingress_checker (
    input  logic               clk,
    input  logic               rst_n,
    input  pkt_pkg::out_beat_t out,
    input  logic               pause0,
    input  logic               pause1,
    input  logic [15:0]        pkt_count,
    output int                 checked,   // packets seen complete at the output.
    output int                 errors
);
    import pkt_pkg::*;

    logic [20:0] exp0 [$];  // {dest, eop, data} per expected beat of port 0.
    logic [20:0] exp1 [$];
    logic [20:0] want;
    logic        open;      // an output packet is in progress.
    logic        open_src;
    int          pause_hits;

    initial begin
        checked    = 0;
        errors     = 0;
        open       = 1'b0;
        open_src   = 1'b0;
        pause_hits = 0;
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // hooks for the testbench.
    // ~~~~~~~~~~~~~~~~~~~~
    task automatic add_expected(input int port, input logic [20:0] entry);
        if (port == 0) exp0.push_back(entry);
        else exp1.push_back(entry);
    endtask

    // nothing may move while the inputs stay quiet.
    task automatic check_quiet(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            if (out.vld || pause0 || pause1 || pkt_count != 16'd0) begin
                errors++;
                $display("FAIL %0t: activity after reset, vld %b pause %b%b count %0d",
                         $time, out.vld, pause0, pause1, pkt_count);
            end
        end
    endtask

    task automatic clear_pause_hits();
        pause_hits = 0;
    endtask

    task automatic check_pause_rose();
        if (pause_hits == 0) begin
            errors++;
            $display("FAIL %0t: pause never rose while a buffer was filling", $time);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // output compare.
    // ~~~~~~~~~~~~~~~~~~~~
    always @(negedge clk) begin  // outputs settle well before the falling edge.
        if (!rst_n) begin
            open = 1'b0;
        end else begin
            if (pause0 || pause1) pause_hits++;
            if (out.vld) begin
                if (open && out.src != open_src) begin
                    errors++;  // two ports mixed inside one packet.
                    $display("FAIL %0t: port %0d beat inside a port %0d packet",
                             $time, out.src, open_src);
                end
                if ((out.src == 1'b0 && exp0.size() == 0) ||
                    (out.src == 1'b1 && exp1.size() == 0)) begin
                    errors++;
                    $display("FAIL %0t: beat from port %0d with nothing expected",
                             $time, out.src);
                end else begin
                    if (out.src == 1'b0) want = exp0.pop_front();
                    else want = exp1.pop_front();  // order is kept per port only.
                    if ({out.dest, out.eop, out.data} !== want) begin
                        errors++;
                        $display("FAIL %0t: port %0d got dest %h eop %b data %h, %s %h %b %h",
                                 $time, out.src, out.dest, out.eop, out.data, "expected",
                                 want[20:17], want[16], want[15:0]);
                    end
                end
                open     = !out.eop;
                open_src = out.src;
                if (out.eop) begin
                    checked++;
                    if (pkt_count != checked[15:0]) begin  // one count per packet.
                        errors++;
                        $display("FAIL %0t: pkt_count %0d after %0d packets",
                                 $time, pkt_count, checked);
                    end
                end
            end
        end
    end

endmodule

// File: bench/switch_ingress_tb.sv
`timescale 1ns/10ps

module switch_ingress_tb;
    import pkt_pkg::*;

    localparam int buf_aw = 6;  // 64 halfwords per frontend.

    logic        clk;
    logic        rst_n;
    in_beat_t    in_drv [2];    // source beat per port.
    wire [1:0]   pause_w;
    out_beat_t   out;
    logic [15:0] pkt_count;
    int          checked;
    int          chk_errors;

    int seed;
    int seq_cnt [2];   // next sequence number per port.
    int pkts_sent;
    int hw_sent;       // halfwords handed to the DUT, sizes the watchdog.
    int tests_run;
    int tests_failed;
    int err_before;
    int wd_cycles;

    switch_ingress #(.buf_aw(buf_aw)) dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .in0       (in_drv[0]),
        .in1       (in_drv[1]),
        .pause0    (pause_w[0]),
        .pause1    (pause_w[1]),
        .out       (out),
        .pkt_count (pkt_count)
    );

    ingress_checker chk0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .out       (out),
        .pause0    (pause_w[0]),
        .pause1    (pause_w[1]),
        .pkt_count (pkt_count),
        .checked   (checked),
        .errors    (chk_errors)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // 8 ns period.
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // reference model.
    // ~~~~~~~~~~~~~~~~~~~~
    function automatic port_id_t dest_of(input int port, input int seq);
        int d;
        d = seq * 5 + port * 9;
        return d[3:0];
    endfunction

    // halfword idx of a packet, idx 0 is the header.
    function automatic hw_t packet_word(input int port, input int seq, input int len,
                                        input int idx);
        if (idx == 0) return {len[8:0], 3'b000, dest_of(port, seq)};
        return {port[0], seq[6:0], idx[7:0]} ^ {len[7:0], 8'h3c};
    endfunction

    task automatic push_expected(input int port, input int seq, input int len);
        logic [20:0] entry;
        for (int i = 0; i < len; i++) begin
            entry = {dest_of(port, seq), i == len - 1, packet_word(port, seq, len, i)};
            chk0.add_expected(port, entry);
        end
        pkts_sent++;
        hw_sent += len;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // stimulus.
    // ~~~~~~~~~~~~~~~~~~~~
    task automatic send_burst(input int port, input int count, input int len_min,
                              input int len_max, input int gap_max);
        int len;
        int seq;
        int idx;
        int gap;
        for (int p = 0; p < count; p++) begin
            len = len_min + ({$random(seed)} % (len_max - len_min + 1));
            seq = seq_cnt[port];
            seq_cnt[port]++;
            push_expected(port, seq, len);
            idx = 0;
            while (idx < len) begin
                @(negedge clk);
                if (pause_w[port]) begin
                    in_drv[port] = '0;  // hold until pause drops.
                end else begin
                    in_drv[port] = {idx == 0, idx == len - 1, 1'b1,
                                    packet_word(port, seq, len, idx)};
                    idx++;
                    gap = {$random(seed)} % (gap_max + 1);
                    repeat (gap) begin
                        @(negedge clk);
                        in_drv[port] = '0;
                    end
                end
            end
        end
        @(negedge clk);
        in_drv[port] = '0;  // port goes quiet after the burst.
    endtask

    // checker counts on the falling edge, so look on the rising one.
    task automatic wait_drained();
        while (checked < pkts_sent) @(posedge clk);
    endtask

    task automatic finish_test(input string name);
        int new_err;
        new_err = chk_errors - err_before;
        tests_run++;
        if (new_err == 0) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, new_err);
        end
        err_before = chk_errors;
    endtask

    // watchdog, four cycles per halfword sent plus a margin.
    initial begin
        wd_cycles = 0;
        while (wd_cycles <= hw_sent * 4 + 2000) begin
            @(posedge clk);
            wd_cycles++;
        end
        $display("timeout: output stopped before all packets arrived, %0d of %0d seen",
                 checked, pkts_sent);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        seed         = 15858;
        rst_n        = 1'b0;
        in_drv[0]    = '0;
        in_drv[1]    = '0;
        seq_cnt[0]   = 0;
        seq_cnt[1]   = 0;
        pkts_sent    = 0;
        hw_sent      = 0;
        tests_run    = 0;
        tests_failed = 0;
        err_before   = 0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        chk0.check_quiet(16);
        finish_test("idle after reset");

        for (int len = 2; len <= 20; len++) begin  // one packet of each length.
            send_burst(0, 1, len, len, 0);
            wait_drained();
        end
        finish_test("single packets on port 0");

        send_burst(1, 8, 2, 24, 0);
        wait_drained();
        finish_test("back-to-back packets on port 1");

        fork
            send_burst(0, 6, 2, 30, 0);
            send_burst(1, 6, 2, 30, 0);
        join
        wait_drained();
        finish_test("both ports loaded");

        // the port that loses arbitration fills its buffer.
        chk0.clear_pause_hits();
        fork
            send_burst(0, 1, 100, 100, 0);
            send_burst(1, 1, 100, 100, 0);
        join
        wait_drained();
        chk0.check_pause_rose();
        finish_test("packets longer than the buffer");

        fork
            send_burst(0, 4, 2, 40, 3);
            send_burst(1, 4, 2, 40, 3);
        join
        wait_drained();
        finish_test("slow sources with gaps");

        $display("tests %0d, failed %0d, errors %0d, packets %0d",
                 tests_run, tests_failed, chk_errors, checked);
        if (chk_errors == 0 && tests_failed == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: switch_ingress.f
src/pkt_pkg.sv
src/port_wr_frontend.sv
src/match_arbiter.sv
src/stream_merger.sv
src/switch_ingress.sv
bench/ingress_checker.sv
bench/switch_ingress_tb.sv
